//--- src.f
hdl/board_pkg.sv
hdl/top.sv
hdl/tm1638_board_controller.sv
hdl/board_specific_top.sv
verification/tb_board_properties.sv
verification/tb_board.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_board -o sim_tb_board
./obj_dir/sim_tb_board > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

//--- verification/tb_board.sv
module tb_board;

    import board_pkg::*;

    localparam int frame_cycles  = 26000;  // 192 bits at 124 clocks plus strobe gaps
    localparam int total_frames  = 24;
    localparam int timeout_limit = frame_cycles * total_frames;

    logic       clk_125;
    logic       arst_n;
    logic [3:0] key;
    logic [3:0] sw;
    logic [3:0] led;
    wire  [7:0] gpio_je;

    logic [7:0] key_pat;      // Keys held on the TM1638 module
    logic       model_drive;
    logic       model_bit;
    logic [7:0] cur_byte;
    logic [7:0] txn [0:31];
    logic [7:0] disp [0:15];
    int         nbits;
    int         nbytes;
    int         txn_idx;
    int         frame_count;
    int         cycles;
    int         seed;
    count_t     exp_count;

    board_specific_top board_specific_top_inst (
        .clk_125 (clk_125),
        .arst_n  (arst_n),
        .key     (key),
        .sw      (sw),
        .led     (led),
        .gpio_je (gpio_je)
    );

    pullup (gpio_je[2]);
    assign gpio_je[2] = model_drive ? model_bit : 1'bz;

    always #4 clk_125 = ~clk_125;

    // ------------------------------------------------------------------------
    // Checks and helpers

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    function automatic logic [7:0] seg_code(input logic [3:0] n);  // Bit 0 is segment a
        case (n)
            4'h0: return 8'h3F;
            4'h1: return 8'h06;
            4'h2: return 8'h5B;
            4'h3: return 8'h4F;
            4'h4: return 8'h66;
            4'h5: return 8'h6D;
            4'h6: return 8'h7D;
            4'h7: return 8'h07;
            4'h8: return 8'h7F;
            4'h9: return 8'h6F;
            4'hA: return 8'h77;
            4'hB: return 8'h7C;
            4'hC: return 8'h39;
            4'hD: return 8'h5E;
            4'hE: return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

    task automatic wait_frames(input int n);
        int target;
        target = frame_count + n;
        while (frame_count < target)
            @(posedge clk_125);
        @(negedge clk_125);
    endtask

    task automatic check_display(input string name);
        for (int d = 0; d < 8; d++) begin
            check_value({name, " segments"}, seg_code(exp_count[4 * d +: 4]), disp[2 * d]);
            check_value({name, " led"}, {7'b0, exp_count[d]}, disp[2 * d + 1]);
        end
    endtask

    task automatic press_module(input int k);
        key_pat = 8'(1 << k);
        wait_frames(2);           // At least one full key read with the key down
        key_pat = 8'h00;
        wait_frames(2);
    endtask

    task automatic press_board(input int k);
        key[k] = 1'b1;
        repeat (4) @(negedge clk_125);
        key[k] = 1'b0;
        repeat (2) @(negedge clk_125);
    endtask

    // ------------------------------------------------------------------------
    // TM1638 chip model

    always @(negedge gpio_je[0]) begin
        nbits  = 0;
        nbytes = 0;
    end

    always @(posedge gpio_je[1]) begin
        if (gpio_je[0] === 1'b0) begin
            cur_byte = {gpio_je[2], cur_byte[7:1]};  // LSB first
            nbits++;
            if (nbits == 8) begin
                txn[nbytes] = cur_byte;
                nbytes++;
                nbits = 0;
            end
        end
    end

    // Read bits are put on the line while sio_clk is low
    always @(negedge gpio_je[1]) begin
        if (gpio_je[0] === 1'b0 && nbytes >= 1 && txn[0] == cmd_read_keys) begin
            model_drive = 1'b1;
            if (nbits == 0)
                model_bit = key_pat[(nbytes - 1) % 4];
            else if (nbits == 4)
                model_bit = key_pat[(nbytes - 1) % 4 + 4];
            else
                model_bit = 1'b0;
        end
    end

    always @(posedge gpio_je[0]) begin
        model_drive = 1'b0;
        if (arst_n) begin
            case (txn_idx)
                0: begin
                    check_value("write command", cmd_write_auto, txn[0]);
                    check_value("write length", 1, nbytes);
                end
                1: begin
                    check_value("address command", cmd_addr_zero, txn[0]);
                    check_value("display length", 17, nbytes);
                    for (int i = 0; i < 16; i++)
                        disp[i] = txn[i + 1];
                end
                2: begin
                    check_value("display on command", cmd_display_on, txn[0]);
                    check_value("display on length", 1, nbytes);
                end
                default: begin
                    check_value("read command", cmd_read_keys, txn[0]);
                    check_value("read length", 5, nbytes);
                    frame_count++;
                end
            endcase
            txn_idx = (txn_idx + 1) % 4;
        end
    end

    // ------------------------------------------------------------------------
    // Timeout

    always @(posedge clk_125) begin
        cycles++;
        if (cycles > timeout_limit) begin
            $display("Timeout after %0d cycles without finishing the tests", cycles);
            $display("Verification failed");
            $fatal(1);
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus

    initial begin
        clk_125     = 1'b0;
        arst_n      = 1'b0;
        key         = '0;
        sw          = '0;
        key_pat     = '0;
        model_drive = 1'b0;
        model_bit   = 1'b0;
        cur_byte    = '0;
        nbits       = 0;
        nbytes      = 0;
        txn_idx     = 0;
        frame_count = 0;
        cycles      = 0;
        seed        = 42;
        exp_count   = '0;

        repeat (5) @(negedge clk_125);
        arst_n = 1'b1;

        wait_frames(2);
        check_display("reset display");

        repeat (2) begin
            press_module(0);
            exp_count = exp_count + 1;
        end
        check_display("module key 0");

        repeat (2) begin
            sw = 4'($random(seed));
            press_module(2);
            exp_count = exp_count + count_t'(sw[2:0]);
        end
        check_display("module key 2");

        press_board(1);
        exp_count = '0;
        check_value("board key 1 led", exp_count[3:0], led);
        press_board(0);
        press_board(0);
        exp_count = exp_count + 2;
        check_value("board key 0 led", exp_count[3:0], led);
        wait_frames(2);
        check_display("board keys");

        $display("Verification passed");
        $finish;
    end

endmodule

//--- verification/tb_board_properties.sv
module tb_board_properties (
    input logic       clk,
    input logic       arst_n,
    input logic       stb,
    input logic       sclk,
    input logic       data_oe,
    input logic       read_phase,
    input logic [3:0] led,
    input logic [7:0] key_top
);

    logic [7:0] key_q;    // Merged keys one clock earlier
    logic       pressed;  // Some merged key has just gone down

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            key_q <= '0;
        else
            key_q <= key_top;
    end

    assign pressed = |(key_top & ~key_q);

    // ------------------------------------------------------------------------
    // Serial bus protocol

    property p_clk_high_when_idle;
        @(posedge clk) disable iff (!arst_n) stb |-> sclk;
    endproperty

    property p_released_during_read;
        @(posedge clk) disable iff (!arst_n) read_phase |-> !data_oe;
    endproperty

    a_clk_high_when_idle : assert property (p_clk_high_when_idle)
        else $error("Serial clock low while strobe is high");

    a_released_during_read : assert property (p_released_during_read)
        else $error("Data pin driven during key read bytes");

    // ------------------------------------------------------------------------
    // LEDs and reset

    // Count moves only on the clock after a key edge
    property p_led_on_press;
        @(posedge clk) disable iff (!arst_n) !$stable(led) |-> $past(pressed);
    endproperty

    a_led_on_press : assert property (p_led_on_press)
        else $error("Board LEDs changed without a key press");

    a_reset_idle : assert property (@(posedge clk) !arst_n |-> stb && !data_oe)
        else $error("Bus not idle during reset");

endmodule

bind board_specific_top tb_board_properties props_inst (
    .clk        (clk_125),
    .arst_n     (arst_n),
    .stb        (sio_stb),
    .sclk       (sio_clk),
    .data_oe    (sio_data_oe),
    .read_phase (!sio_stb && (i_tm1638.byte_idx >= 5'd20)),  // Bytes 20..23 are key reads
    .led        (led),
    .key_top    (key_top)
);

//--- hdl/board_specific_top.sv
module board_specific_top (
    input  logic                           clk_125,
    input  logic                           arst_n,
    input  logic [board_pkg::w_key  - 1:0] key,
    input  logic [board_pkg::w_sw   - 1:0] sw,
    output logic [board_pkg::w_led  - 1:0] led,
    inout  wire  [board_pkg::w_gpio - 1:0] gpio_je
);

    import board_pkg::*;

    key_vec_t   key_top;
    key_vec_t   key_tm;
    led_vec_t   led_top;
    led_vec_t   led_tm;
    digit_vec_t digit_top;
    seg_t       abcdefgh;
    seg_t       hgfedcba;

    logic       sio_clk;
    logic       sio_stb;
    logic       sio_data_out;
    logic       sio_data_oe;
    logic       sio_data_in;

    // ------------------------------------------------------------------------
    // Board and module signals share one bus

    assign key_top = key_vec_t'(key) | key_tm;  // Either key source counts as a press

    assign led    = led_top[w_led - 1:0];
    assign led_tm = led_top;                    // Module shows the full pattern

    // ------------------------------------------------------------------------

    top i_top (
        .clk      (clk_125),
        .arst_n   (arst_n),
        .key      (key_top),
        .sw       (sw[w_sw - 2:0]),             // Last switch is spare
        .led      (led_top),
        .abcdefgh (abcdefgh),
        .digit    (digit_top)
    );

    // TM1638 wants segment a in bit 0
    always_comb begin
        for (int i = 0; i < $bits(seg_t); i++) begin
            hgfedcba[i] = abcdefgh[$bits(seg_t) - 1 - i];
        end
    end

    tm1638_board_controller i_tm1638 (
        .clk          (clk_125),
        .arst_n       (arst_n),
        .hgfedcba     (hgfedcba),
        .digit        (digit_top),
        .ledr         (led_tm),
        .sio_data_in  (sio_data_in),
        .keys         (key_tm),
        .sio_clk      (sio_clk),
        .sio_stb      (sio_stb),
        .sio_data_out (sio_data_out),
        .sio_data_oe  (sio_data_oe)
    );

    // ------------------------------------------------------------------------
    // Pmod JE pins

    assign gpio_je[0] = sio_stb;
    assign gpio_je[1] = sio_clk;
    assign gpio_je[2] = sio_data_oe ? sio_data_out : 1'bz;  // Released while reading keys
    assign sio_data_in = gpio_je[2];

endmodule

//--- hdl/tm1638_board_controller.sv
module tm1638_board_controller (
    input  logic                    clk,
    input  logic                    arst_n,
    input  board_pkg::seg_t         hgfedcba,
    input  board_pkg::digit_vec_t   digit,
    input  board_pkg::led_vec_t     ledr,
    input  logic                    sio_data_in,
    output board_pkg::key_vec_t     keys,
    output logic                    sio_clk,
    output logic                    sio_stb,
    output logic                    sio_data_out,
    output logic                    sio_data_oe
);

    import board_pkg::*;

    typedef enum logic [2:0] {
        idle,
        strobe_low,
        shift_out,
        shift_in,
        strobe_gap
    } sio_state_t;

    sio_state_t               state;
    logic [w_sio_timer - 1:0] timer;
    logic                     tick;
    logic                     phase;     // 0 while sio_clk is low, 1 while high
    logic [2:0]               bit_cnt;
    logic [4:0]               byte_idx;  // 24 bytes per frame
    logic [4:0]               disp_idx;
    logic                     txn_end;
    logic                     byte_done;
    logic [7:0]               tx_byte;
    logic [7:0]               rx_byte;
    key_vec_t                 key_acc;
    seg_t                     seg_r [w_digit_top];

    // ------------------------------------------------------------------------
    // Digit capture

    always_ff @(posedge clk) begin
        for (int i = 0; i < w_digit_top; i++) begin
            if (digit[i])
                seg_r[i] <= hgfedcba;
        end
    end

    // ------------------------------------------------------------------------
    // Half-period timer

    assign tick = (timer == w_sio_timer'(sio_half_period - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            timer <= '0;
        else if (tick)
            timer <= '0;
        else
            timer <= timer + w_sio_timer'(1);
    end

    // ------------------------------------------------------------------------
    // Frame layout
    // 0 write cmd | 1 address cmd, 2..17 display | 18 display on | 19 read cmd, 20..23 keys

    assign txn_end   = (byte_idx == 5'd0)  || (byte_idx == 5'd17) ||
                       (byte_idx == 5'd18) || (byte_idx == 5'd23);
    assign byte_done = tick && phase && (bit_cnt == 3'd7);
    assign disp_idx  = byte_idx - 5'd2;

    always_comb begin
        tx_byte = 8'h00;
        case (byte_idx)
            5'd0:    tx_byte = cmd_write_auto;
            5'd1:    tx_byte = cmd_addr_zero;
            5'd18:   tx_byte = cmd_display_on;
            5'd19:   tx_byte = cmd_read_keys;
            default: begin
                if (byte_idx <= 5'd17) begin  // Segment byte, then LED byte per digit
                    if (disp_idx[0])
                        tx_byte = {7'b0, ledr[disp_idx[3:1]]};
                    else
                        tx_byte = seg_r[disp_idx[3:1]];
                end
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Bus FSM

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= idle;
            phase    <= 1'b0;
            bit_cnt  <= '0;
            byte_idx <= '0;
        end else if (tick) begin
            case (state)
                idle:       state <= strobe_low;
                strobe_low: state <= shift_out;   // Every transaction opens with a command
                shift_out, shift_in: begin
                    phase <= ~phase;
                    if (phase) begin
                        bit_cnt <= bit_cnt + 3'd1;  // Wraps to 0 after bit 7
                        if (bit_cnt == 3'd7) begin
                            if (txn_end) begin
                                state <= strobe_gap;
                            end else begin
                                byte_idx <= byte_idx + 5'd1;
                                state    <= (byte_idx >= 5'd19) ? shift_in : shift_out;
                            end
                        end
                    end
                end
                strobe_gap: begin
                    byte_idx <= (byte_idx == 5'd23) ? 5'd0 : byte_idx + 5'd1;
                    state    <= strobe_low;
                end
                default:    state <= idle;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Key readback

    always_ff @(posedge clk) begin
        if (tick && (state == shift_in) && !phase)
            rx_byte <= {sio_data_in, rx_byte[7:1]};   // Sampled as sio_clk rises, LSB first
        if (byte_done && (state == shift_in)) begin
            key_acc[byte_idx[1:0]]         <= rx_byte[0];  // Bytes 20..23 map to 0..3
            key_acc[{1'b1, byte_idx[1:0]}] <= rx_byte[4];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            keys <= '0;
        else if ((state == strobe_gap) && (timer == '0) && (byte_idx == 5'd23))
            keys <= key_acc;   // First cycle after the read strobe rises
    end

    // ------------------------------------------------------------------------
    // Bus pins

    assign sio_stb      = (state == idle) || (state == strobe_gap);
    assign sio_clk      = !(((state == shift_out) || (state == shift_in)) && !phase);
    assign sio_data_oe  = (state == shift_out);
    assign sio_data_out = tx_byte[bit_cnt];

endmodule

//--- hdl/top.sv
module top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  board_pkg::key_vec_t           key,
    input  logic [board_pkg::w_sw - 2:0]  sw,
    output board_pkg::led_vec_t           led,
    output board_pkg::seg_t               abcdefgh,
    output board_pkg::digit_vec_t         digit
);

    import board_pkg::*;

    key_vec_t    key_r;
    key_vec_t    key_rise;
    count_t      count;
    logic [10:0] refresh;        // Upper bits pick the digit, 256 clocks each
    logic [2:0]  digit_idx;
    logic [3:0]  nibble;

    // ------------------------------------------------------------------------
    // Press counter

    assign key_rise = key & ~key_r;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            key_r <= '0;
            count <= '0;
        end else begin
            key_r <= key;
            if (key_rise[1])
                count <= '0;                      // Clear wins over the others
            else if (key_rise[0])
                count <= count + count_t'(1);
            else if (key_rise[2])
                count <= count + count_t'(sw);    // Add switch value
        end
    end

    assign led = count[w_led_top - 1:0];

    // ------------------------------------------------------------------------
    // Digit scan and hex decoder

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            refresh <= '0;
        else
            refresh <= refresh + 11'd1;
    end

    assign digit_idx = refresh[10:8];
    assign nibble    = count[{digit_idx, 2'b00} +: 4];  // Digit 0 is the low nibble

    always_comb begin
        digit            = '0;
        digit[digit_idx] = 1'b1;
    end

    always_comb begin
        case (nibble)        // abcdefgh, point always off
            4'h0:    abcdefgh = 8'b1111_1100;
            4'h1:    abcdefgh = 8'b0110_0000;
            4'h2:    abcdefgh = 8'b1101_1010;
            4'h3:    abcdefgh = 8'b1111_0010;
            4'h4:    abcdefgh = 8'b0110_0110;
            4'h5:    abcdefgh = 8'b1011_0110;
            4'h6:    abcdefgh = 8'b1011_1110;
            4'h7:    abcdefgh = 8'b1110_0000;
            4'h8:    abcdefgh = 8'b1111_1110;
            4'h9:    abcdefgh = 8'b1111_0110;
            4'hA:    abcdefgh = 8'b1110_1110;
            4'hB:    abcdefgh = 8'b0011_1110;
            4'hC:    abcdefgh = 8'b1001_1100;
            4'hD:    abcdefgh = 8'b0111_1010;
            4'hE:    abcdefgh = 8'b1001_1110;
            default: abcdefgh = 8'b1000_1110;   // F
        endcase
    end

endmodule

//--- hdl/board_pkg.sv
package board_pkg;

    // ------------------------------------------------------------------------
    // Board and display resources

    localparam int clk_mhz     = 125;  // Main clock frequency
    localparam int w_key       = 4;    // Buttons on the board
    localparam int w_sw        = 4;    // Switches on the board
    localparam int w_led       = 4;    // LEDs on the board
    localparam int w_gpio      = 8;    // Pmod connector

    localparam int w_key_tm    = 8;    // TM1638 keys
    localparam int w_led_tm    = 8;    // TM1638 LEDs
    localparam int w_digit_tm  = 8;    // TM1638 digits

    // Board and module signals overlap, so the wider of the two wins
    localparam int w_key_top   = w_key_tm   > w_key ? w_key_tm : w_key;
    localparam int w_led_top   = w_led_tm   > w_led ? w_led_tm : w_led;
    localparam int w_digit_top = w_digit_tm;  // Board has no digits of its own

    // ------------------------------------------------------------------------
    // Serial bus timing and TM1638 commands

    localparam int sio_half_period = clk_mhz / 2;  // Clocks per half sio_clk period
    localparam int w_sio_timer     = $clog2(sio_half_period);

    localparam logic [7:0] cmd_write_auto = 8'h40;  // Write data, address auto-increment
    localparam logic [7:0] cmd_addr_zero  = 8'hC0;  // Start at display address 0
    localparam logic [7:0] cmd_display_on = 8'h8F;  // Display on, full brightness
    localparam logic [7:0] cmd_read_keys  = 8'h42;  // Read key scan data

    typedef logic [7:0]               seg_t;
    typedef logic [w_key_top   - 1:0] key_vec_t;
    typedef logic [w_led_top   - 1:0] led_vec_t;
    typedef logic [w_digit_top - 1:0] digit_vec_t;
    typedef logic [31:0]              count_t;

endpackage
